//--- cpu_mem_pkg.sv
package cpu_mem_pkg;

    // Datapath width, also the byte address width
    localparam int XLEN = 32;

    // Destination register field, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // Start of the memory-mapped peripheral window
    // Any byte address at or above this goes to the peripheral block
    localparam logic [XLEN-1:0] PERIPH_BASE = 32'hFFFF_0000;

    // Output registers in the peripheral block
    localparam int NUM_PERIPH = 2;

    // Memory opcode carried down the pipe from execute
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,     // ALU op or bubble
        MEM_LOAD  = 2'b01,     // Word load
        MEM_STORE = 2'b10      // Word store
    } mem_op_e;

    // Byte offset bits below the word index
    localparam int WORD_OFFS_W = 2;

    // Address bit picking the peripheral register
    localparam int PERIPH_SEL_BIT = 2;

endpackage

//--- data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int RAM_WORDS = 1024                                  // Depth, power of two
) (
    input  logic                            clk,
    input  logic [$clog2(RAM_WORDS)-1:0]    addr,                   // Word index
    input  logic [cpu_mem_pkg::XLEN-1:0]    wdata,
    input  logic                            we,                     // Write this edge
    output logic [cpu_mem_pkg::XLEN-1:0]    rdata                   // Async read
);
    import cpu_mem_pkg::*;

    // Word storage, contents undefined until written
    logic [XLEN-1:0] mem [RAM_WORDS];

    // Write at the rising edge
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    // Read is combinational, so a store at edge k is visible
    // to the op in the mem stage right after that edge
    assign rdata = mem[addr];

endmodule

//--- periph_regs.sv
`timescale 1ns/100ps

module periph_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            we,                     // Store into window
    input  logic                            sel,                    // Address bit 2
    input  logic [cpu_mem_pkg::XLEN-1:0]    wdata,
    output logic [cpu_mem_pkg::XLEN-1:0]    rdata,                  // Readback of selected reg
    output logic [cpu_mem_pkg::XLEN-1:0]    periph_out0,
    output logic [cpu_mem_pkg::XLEN-1:0]    periph_out1,
    output logic                            periph_wr0,             // One-cycle write strobe
    output logic                            periph_wr1
);
    import cpu_mem_pkg::*;

    logic [XLEN-1:0]       regs [NUM_PERIPH];                       // Output registers
    logic [NUM_PERIPH-1:0] wr_q;                                    // Strobes, one per reg

    // Update on store, strobe high for the following cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_PERIPH; i++)
            begin
                regs[i] <= '0;
            end
            wr_q <= '0;
        end
        else
        begin
            wr_q <= '0;                                             // Default no strobe
            if (we)
            begin
                regs[sel] <= wdata;
                wr_q[sel] <= 1'b1;
            end
        end
    end

    // Readback so software sees what it wrote
    assign rdata = regs[sel];

    assign periph_out0 = regs[0];
    assign periph_out1 = regs[1];
    assign periph_wr0  = wr_q[0];
    assign periph_wr1  = wr_q[1];

endmodule

//--- mem_stage.sv
`timescale 1ns/100ps

module mem_stage #(
    parameter int RAM_WORDS = 1024                                  // RAM depth in words
) (
    input  logic                                clk,
    input  logic                                rst,
    input  cpu_mem_pkg::mem_op_e                ex_op,              // From execute
    input  logic [cpu_mem_pkg::XLEN-1:0]        ex_alu_result,      // Also byte address
    input  logic [cpu_mem_pkg::XLEN-1:0]        ex_store_data,
    input  logic                                ex_reg_write,
    input  logic [cpu_mem_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  logic                                ex_mem_to_reg,
    input  logic [cpu_mem_pkg::XLEN-1:0]        ram_rdata,          // RAM read port
    input  logic [cpu_mem_pkg::XLEN-1:0]        periph_rdata,       // Peripheral readback
    output logic [$clog2(RAM_WORDS)-1:0]        ram_addr,           // Word index
    output logic [cpu_mem_pkg::XLEN-1:0]        ram_wdata,
    output logic                                ram_we,
    output logic                                periph_we,
    output logic                                periph_sel,
    output logic [cpu_mem_pkg::XLEN-1:0]        periph_wdata,
    output cpu_mem_pkg::mem_op_e                mem_op,             // To writeback
    output logic [cpu_mem_pkg::XLEN-1:0]        mem_alu_result,
    output logic [cpu_mem_pkg::XLEN-1:0]        mem_rdata,
    output logic                                mem_reg_write,
    output logic [cpu_mem_pkg::REG_ADDR_W-1:0]  mem_rd,
    output logic                                mem_mem_to_reg
);
    import cpu_mem_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);                       // RAM index width

    logic [XLEN-1:0] store_data_q;                                  // Registered store data
    logic            in_window;                                     // Peripheral space hit

    // EX/MEM stage register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_op         <= MEM_NONE;                             // Bubble after reset
            mem_alu_result <= '0;
            store_data_q   <= '0;
            mem_reg_write  <= 1'b0;
            mem_rd         <= '0;
            mem_mem_to_reg <= 1'b0;
        end
        else
        begin
            mem_op         <= ex_op;
            mem_alu_result <= ex_alu_result;
            store_data_q   <= ex_store_data;
            mem_reg_write  <= ex_reg_write;
            mem_rd         <= ex_rd;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

    // Address decode, top of map is peripherals
    assign in_window = (mem_alu_result >= PERIPH_BASE);

    // RAM side, index wraps modulo depth
    assign ram_addr  = mem_alu_result[WORD_OFFS_W +: IDX_W];
    assign ram_wdata = store_data_q;
    assign ram_we    = (mem_op == MEM_STORE) && !in_window;         // Stores only

    // Peripheral side
    assign periph_sel   = mem_alu_result[PERIPH_SEL_BIT];           // Reg 0 or 1
    assign periph_wdata = store_data_q;
    assign periph_we    = (mem_op == MEM_STORE) && in_window;

    // Load data steering
    assign mem_rdata = in_window ? periph_rdata : ram_rdata;

endmodule

//--- writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  cpu_mem_pkg::mem_op_e                mem_op,             // Opcode in mem stage
    input  logic [cpu_mem_pkg::XLEN-1:0]        mem_alu_result,
    input  logic [cpu_mem_pkg::XLEN-1:0]        mem_rdata,          // Load data, RAM or periph
    input  logic                                mem_reg_write,
    input  logic [cpu_mem_pkg::REG_ADDR_W-1:0]  mem_rd,
    input  logic                                mem_mem_to_reg,     // Pick load data
    output logic                                wb_reg_write,       // Register file write port
    output logic [cpu_mem_pkg::REG_ADDR_W-1:0]  wb_rd,
    output logic [cpu_mem_pkg::XLEN-1:0]        wb_data,
    output logic                                wb_mem_done         // Load or store retired
);
    import cpu_mem_pkg::*;

    logic [XLEN-1:0] result;                                        // Selected writeback value
    logic            mem_access;                                    // Load or store in flight

    // Result mux ahead of the MEM/WB register
    assign result     = mem_mem_to_reg ? mem_rdata : mem_alu_result;
    assign mem_access = (mem_op == MEM_LOAD) || (mem_op == MEM_STORE);

    // MEM/WB register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
            wb_data      <= '0;
            wb_mem_done  <= 1'b0;
        end
        else
        begin
            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
            wb_data      <= result;
            wb_mem_done  <= mem_access;                             // Pulse per memory op
        end
    end

endmodule

//--- mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top #(
    parameter int RAM_WORDS = 1024                                  // Passed to stage and RAM
) (
    input  logic                                clk,
    input  logic                                rst,
    input  cpu_mem_pkg::mem_op_e                ex_op,
    input  logic [cpu_mem_pkg::XLEN-1:0]        ex_alu_result,
    input  logic [cpu_mem_pkg::XLEN-1:0]        ex_store_data,
    input  logic                                ex_reg_write,
    input  logic [cpu_mem_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  logic                                ex_mem_to_reg,
    output logic                                wb_reg_write,
    output logic [cpu_mem_pkg::REG_ADDR_W-1:0]  wb_rd,
    output logic [cpu_mem_pkg::XLEN-1:0]        wb_data,
    output logic                                wb_mem_done,
    output logic [cpu_mem_pkg::XLEN-1:0]        periph_out0,        // Peripheral outputs
    output logic [cpu_mem_pkg::XLEN-1:0]        periph_out1,
    output logic                                periph_wr0,
    output logic                                periph_wr1
);
    import cpu_mem_pkg::*;

    // Mem stage to RAM
    logic [$clog2(RAM_WORDS)-1:0] ram_addr;
    logic [XLEN-1:0]              ram_wdata;
    logic [XLEN-1:0]              ram_rdata;
    logic                         ram_we;

    // Mem stage to peripherals
    logic                         periph_we;
    logic                         periph_sel;
    logic [XLEN-1:0]              periph_wdata;
    logic [XLEN-1:0]              periph_rdata;

    // Mem stage to writeback
    mem_op_e                      mem_op;
    logic [XLEN-1:0]              mem_alu_result;
    logic [XLEN-1:0]              mem_rdata;
    logic                         mem_reg_write;
    logic [REG_ADDR_W-1:0]        mem_rd;
    logic                         mem_mem_to_reg;

    mem_stage #(.RAM_WORDS(RAM_WORDS)) mem_stage_inst (.*);

    data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_inst (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    periph_regs periph_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .we          (periph_we),
        .sel         (periph_sel),
        .wdata       (periph_wdata),
        .rdata       (periph_rdata),
        .periph_out0 (periph_out0),
        .periph_out1 (periph_out1),
        .periph_wr0  (periph_wr0),
        .periph_wr1  (periph_wr1)
    );

    writeback_stage writeback_stage_inst (.*);                      // Names match one to one

endmodule

//--- mem_wb_props.sv
`timescale 1ns/100ps

module mem_wb_props (
    input  logic                                clk,
    input  logic                                rst,
    input  cpu_mem_pkg::mem_op_e                ex_op,
    input  logic [cpu_mem_pkg::XLEN-1:0]        ex_alu_result,
    input  logic                                ex_reg_write,
    input  logic [cpu_mem_pkg::REG_ADDR_W-1:0]  ex_rd,
    input  logic                                ex_mem_to_reg,
    input  logic                                wb_reg_write,
    input  logic [cpu_mem_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  logic [cpu_mem_pkg::XLEN-1:0]        wb_data,
    input  logic                                wb_mem_done,
    input  logic [cpu_mem_pkg::XLEN-1:0]        periph_out0,
    input  logic [cpu_mem_pkg::XLEN-1:0]        periph_out1,
    input  logic                                periph_wr0,
    input  logic                                periph_wr1
);
    import cpu_mem_pkg::*;

    int fail_count = 0;                                             // Tally of failed properties

    // Outputs stay clear while reset is held
    reset_clear: assert property (@(posedge clk) rst && $past(rst) |->
        !wb_reg_write && !wb_mem_done && !periph_wr0 && !periph_wr1 &&
        periph_out0 == '0 && periph_out1 == '0)
    else
    begin
        fail_count++;
        $error("outputs not cleared while reset is held");
    end

    // Op sampled two edges back, non-memory op
    alu_pass: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && $past(ex_op, 2) == MEM_NONE && !$past(ex_mem_to_reg, 2) |->
        wb_data == $past(ex_alu_result, 2) && wb_rd == $past(ex_rd, 2) &&
        wb_reg_write == $past(ex_reg_write, 2) && !wb_mem_done)
    else
    begin
        fail_count++;
        $error("ALU result or control fields not passed to writeback");
    end

    // Strobe only for a window store two edges back, bit 2 picks which
    strobe_0: assert property (@(posedge clk) disable iff (rst)
        periph_wr0 == (!$past(rst, 2) && $past(ex_op, 2) == MEM_STORE &&
        $past(ex_alu_result, 2) >= PERIPH_BASE && !$past(ex_alu_result[2], 2)))
    else
    begin
        fail_count++;
        $error("periph_wr0 does not match the stores into register 0");
    end

    strobe_1: assert property (@(posedge clk) disable iff (rst)
        periph_wr1 == (!$past(rst, 2) && $past(ex_op, 2) == MEM_STORE &&
        $past(ex_alu_result, 2) >= PERIPH_BASE && $past(ex_alu_result[2], 2)))
    else
    begin
        fail_count++;
        $error("periph_wr1 does not match the stores into register 1");
    end

    // Done pulse for every load or store, none for bubbles
    mem_done: assert property (@(posedge clk) disable iff (rst)
        wb_mem_done == (!$past(rst, 2) &&
        ($past(ex_op, 2) == MEM_LOAD || $past(ex_op, 2) == MEM_STORE)))
    else
    begin
        fail_count++;
        $error("wb_mem_done does not follow the memory ops");
    end

endmodule

bind mem_wb_top mem_wb_props mem_wb_props_inst (.*);

//--- tb_mem_wb.sv
`timescale 1ns/100ps

module tb_mem_wb;
    import cpu_mem_pkg::*;

    localparam int RAM_WORDS  = 64;                                 // Small depth makes indices wrap
    localparam int IDX_W      = $clog2(RAM_WORDS);                  // RAM word index width
    localparam int MAX_CYCLES = 1500;                               // Tests need about 1100

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  done;
        logic [XLEN-1:0]       p0;                                  // Peripheral outputs after op
        logic [XLEN-1:0]       p1;
    } wb_exp_t;

    logic                  clk;
    logic                  rst;
    mem_op_e               ex_op;
    logic [XLEN-1:0]       ex_alu_result;
    logic [XLEN-1:0]       ex_store_data;
    logic                  ex_reg_write;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_mem_to_reg;
    logic                  wb_reg_write;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  wb_mem_done;
    logic [XLEN-1:0]       periph_out0;
    logic [XLEN-1:0]       periph_out1;
    logic                  periph_wr0;
    logic                  periph_wr1;

    wb_exp_t         pipe [3];                                      // Delay line with [2] due now
    string           pipe_name [3];
    logic [XLEN-1:0] shadow [RAM_WORDS];                            // Expected RAM contents
    logic [XLEN-1:0] periph_shadow [2];
    logic [31:0]     lfsr = 32'h33ae_c9b0;
    logic [XLEN-1:0] addr;
    string           test_name;
    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    int              errors0;
    int              checks0;
    int              cycles = 0;
    int              prop_fails;

    mem_wb_top #(.RAM_WORDS(RAM_WORDS)) mem_wb_top_inst (.*);

    always #10 clk = ~clk;                                          // 20 ns period

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};                                // One step per bit
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] random_ram_addr();
        return rand_bits(29) << 2;                                  // Word aligned with top bit clear
    endfunction

    function automatic logic [XLEN-1:0] random_periph_addr();
        return PERIPH_BASE | (rand_bits(14) << 2);                  // Bit 2 is random
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    // Drive one op and queue its expected writeback
    task automatic issue_op(input mem_op_e op, input logic [XLEN-1:0] alu,
                            input logic [XLEN-1:0] sdata, input logic rw,
                            input logic [REG_ADDR_W-1:0] rd, input logic m2r);
        wb_exp_t         e;
        logic [XLEN-1:0] ld;
        logic [IDX_W-1:0] idx;
        @(posedge clk);
        ex_op         <= op;
        ex_alu_result <= alu;
        ex_store_data <= sdata;
        ex_reg_write  <= rw;
        ex_rd         <= rd;
        ex_mem_to_reg <= m2r;
        if (alu >= PERIPH_BASE)
        begin
            if (op == MEM_STORE)
                periph_shadow[alu[2]] = sdata;
            ld = periph_shadow[alu[2]];                             // Readback of last store
        end
        else
        begin
            idx = IDX_W'((alu >> 2) % RAM_WORDS);                   // Word index modulo depth
            if (op == MEM_STORE)
                shadow[idx] = sdata;
            ld = shadow[idx];
        end
        e.valid      = 1'b1;
        e.reg_write  = rw;
        e.rd         = rd;
        e.data       = m2r ? ld : alu;
        e.done       = (op == MEM_LOAD) || (op == MEM_STORE);
        e.p0         = periph_shadow[0];
        e.p1         = periph_shadow[1];
        pipe[2]      = pipe[1];
        pipe[1]      = pipe[0];
        pipe[0]      = e;
        pipe_name[2] = pipe_name[1];
        pipe_name[1] = pipe_name[0];
        pipe_name[0] = test_name;
    endtask

    task automatic issue_bubble();
        issue_op(MEM_NONE, '0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors0   = errors;
        checks0   = checks;
    endtask

    // Drain ops in flight before the report
    task automatic end_test();
        repeat (3) issue_bubble();
        tests++;
        $display("Test %-16s %5d checks, %0d errors", test_name, checks - checks0,
                 errors - errors0);
    endtask

    // Writeback outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (pipe[2].valid)
        begin
            check_value(pipe_name[2], "wb_reg_write", XLEN'(pipe[2].reg_write),
                        XLEN'(wb_reg_write));
            check_value(pipe_name[2], "wb_rd", XLEN'(pipe[2].rd), XLEN'(wb_rd));
            check_value(pipe_name[2], "wb_data", pipe[2].data, wb_data);
            check_value(pipe_name[2], "wb_mem_done", XLEN'(pipe[2].done),
                        XLEN'(wb_mem_done));
            check_value(pipe_name[2], "periph_out0", pipe[2].p0, periph_out0);
            check_value(pipe_name[2], "periph_out1", pipe[2].p1, periph_out1);
        end
    end

    initial
    begin
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles before the tests finished", cycles);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        clk              = 1'b0;
        rst              = 1'b1;
        ex_op            = MEM_NONE;
        ex_alu_result    = '0;
        ex_store_data    = '0;
        ex_reg_write     = 1'b0;
        ex_rd            = '0;
        ex_mem_to_reg    = 1'b0;
        periph_shadow[0] = '0;
        periph_shadow[1] = '0;
        for (int i = 0; i < 3; i++)
            pipe[i] = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        @(negedge clk);
        check_value(test_name, "flags", '0,
                    XLEN'({wb_reg_write, wb_mem_done, periph_wr0, periph_wr1}));
        check_value(test_name, "periph_out0", '0, periph_out0);
        check_value(test_name, "periph_out1", '0, periph_out1);
        end_test();

        start_test("alu_pass");
        repeat (40)
            issue_op(MEM_NONE, rand_bits(32), rand_bits(32), 1'(rand_bits(1)),
                     REG_ADDR_W'(rand_bits(5)), 1'b0);
        end_test();

        start_test("ram_store_load");
        for (int i = 0; i < RAM_WORDS; i++)
            issue_op(MEM_STORE, i * 4, rand_bits(32), 1'b0, '0, 1'b0); // Every word defined
        repeat (200)
        begin
            addr = random_ram_addr();
            issue_op(MEM_STORE, addr, rand_bits(32), 1'b0, '0, 1'b0);
            if (rand_bits(1) == 0)
                addr = random_ram_addr();                           // Else same word back to back
            issue_op(MEM_LOAD, addr, '0, 1'b1, REG_ADDR_W'(rand_bits(5)), 1'b1);
        end
        end_test();

        start_test("periph_write");
        repeat (40)
        begin
            issue_op(MEM_STORE, random_periph_addr(), rand_bits(32), 1'b0, '0, 1'b0);
            if (rand_bits(1))
                issue_bubble();                                     // Gap lets the strobe drop
        end
        end_test();

        start_test("periph_readback");
        repeat (40)
        begin
            issue_op(MEM_STORE, random_periph_addr(), rand_bits(32), 1'b0, '0, 1'b0);
            issue_op(MEM_LOAD, random_periph_addr(), '0, 1'b1, REG_ADDR_W'(rand_bits(5)),
                     1'b1);
        end
        end_test();

        start_test("mixed_stream");
        repeat (400)
        begin
            addr = rand_bits(1) ? random_periph_addr() : random_ram_addr();
            case (rand_bits(2))
                0: issue_op(MEM_NONE, rand_bits(32), '0, 1'(rand_bits(1)),
                            REG_ADDR_W'(rand_bits(5)), 1'b0);
                1: issue_op(MEM_LOAD, addr, '0, 1'b1, REG_ADDR_W'(rand_bits(5)), 1'b1);
                default: issue_op(MEM_STORE, addr, rand_bits(32), 1'b0, '0, 1'b0);
            endcase
        end
        end_test();

        @(negedge clk);                                             // Last property edge is past
        prop_fails = mem_wb_top_inst.mem_wb_props_inst.fail_count;
        errors     = errors + prop_fails;
        $display("Summary: %0d tests, %0d checks, %0d failures, %0d from properties",
                 tests, checks, errors, prop_fails);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- tb.f
cpu_mem_pkg.sv
data_ram.sv
periph_regs.sv
mem_stage.sv
writeback_stage.sv
mem_wb_top.sv
mem_wb_props.sv
tb_mem_wb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_mem_wb
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= No errors
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing --assert
SIM_FLAGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
